// File: verilog/fetch_macros.svh
/*
 * Project-wide widths, start address and NOP encoding for the fetch stage.
 * Included by the package, the RTL and the testbench.
 */

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Address and instruction width, one word
`define FETCH_XLEN 32

// Lowest kept address bit, word aligned fetch
`define FETCH_WORD_LSB 2

//////////////////////////////////////////////////////////////////////
// Constants
//////////////////////////////////////////////////////////////////////

// Address loaded by either reset
`define FETCH_START_ADDR 32'h0000_0100

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

// File: verilog/fetch_pkg.sv
/*
 * Types shared by the fetch stage and its testbench: the redirect and
 * branch-prediction bundles and the reason code of the address path.
 */

`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Redirect inputs from the core
    //////////////////////////////////////////////////////////////////////

    // Context switch wins over execute-stage jump
    typedef struct packed {
        logic                   ctx_switch;
        logic [`FETCH_XLEN-1:0] ctx_target;
        logic                   jump;
        logic [`FETCH_XLEN-1:0] jump_target;
    } fetch_redirect_t;

    // Branch prediction from decode
    typedef struct packed {
        logic                   take;
        logic                   rollback;
        logic [`FETCH_XLEN-1:0] target;
    } fetch_bp_t;

    //////////////////////////////////////////////////////////////////////
    // Address update reason
    //////////////////////////////////////////////////////////////////////

    // Why the address register moves at the coming edge
    typedef enum logic [2:0] {
        REASON_HOLD     = 3'd0,
        REASON_SEQ      = 3'd1,
        REASON_CTX      = 3'd2,
        REASON_JUMP     = 3'd3,
        REASON_BP       = 3'd4,
        REASON_ROLLBACK = 3'd5
    } fetch_reason_e;

endpackage

`default_nettype wire

// File: verilog/fetch_addr_gen.sv
/*
 * Instruction address path of the fetch stage. Ranks the redirect sources,
 * holds the word address register and keeps the resume address for a
 * branch-prediction rollback.
 */

`default_nettype none

`include "fetch_macros.svh"

module fetch_addr_gen (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     sys_reset_i,
    input  wire logic                     enable_i,

    input  wire fetch_pkg::fetch_redirect_t redirect_i,
    input  wire fetch_pkg::fetch_bp_t       bp_i,

    output fetch_pkg::fetch_reason_e      reason_o,
    output logic [`FETCH_XLEN-1:0]        iaddr_o
);

    localparam logic [`FETCH_XLEN-1:0] START_ADDR = `FETCH_START_ADDR;

    // Word address, low bits are always zero
    logic [`FETCH_XLEN-1:`FETCH_WORD_LSB] iaddr_q;
    logic [`FETCH_XLEN-1:`FETCH_WORD_LSB] iaddr_next;
    logic [`FETCH_XLEN-1:`FETCH_WORD_LSB] iaddr_advance;
    logic [`FETCH_XLEN-1:`FETCH_WORD_LSB] rollback_addr_q;

    assign iaddr_advance = iaddr_q + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Redirect priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (redirect_i.ctx_switch) begin
            reason_o = fetch_pkg::REASON_CTX;
        end
        else if (redirect_i.jump) begin
            reason_o = fetch_pkg::REASON_JUMP;
        end
        else if (enable_i && bp_i.take) begin
            // Prediction only counts while the stage advances
            reason_o = fetch_pkg::REASON_BP;
        end
        else if (bp_i.rollback) begin
            reason_o = fetch_pkg::REASON_ROLLBACK;
        end
        else if (enable_i) begin
            reason_o = fetch_pkg::REASON_SEQ;
        end
        else begin
            reason_o = fetch_pkg::REASON_HOLD;
        end
    end

    // Next word address per reason
    always_comb begin
        case (reason_o)
            fetch_pkg::REASON_CTX: begin
                iaddr_next = redirect_i.ctx_target[`FETCH_XLEN-1:`FETCH_WORD_LSB];
            end
            fetch_pkg::REASON_JUMP: begin
                iaddr_next = redirect_i.jump_target[`FETCH_XLEN-1:`FETCH_WORD_LSB];
            end
            fetch_pkg::REASON_BP: begin
                iaddr_next = bp_i.target[`FETCH_XLEN-1:`FETCH_WORD_LSB];
            end
            fetch_pkg::REASON_ROLLBACK: begin
                iaddr_next = rollback_addr_q;
            end
            default: begin
                iaddr_next = iaddr_advance;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Address register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iaddr_q <= START_ADDR[`FETCH_XLEN-1:`FETCH_WORD_LSB];
        end
        else if (sys_reset_i) begin
            iaddr_q <= START_ADDR[`FETCH_XLEN-1:`FETCH_WORD_LSB];
        end
        else if (reason_o != fetch_pkg::REASON_HOLD) begin
            iaddr_q <= iaddr_next;
        end
    end

    // Word after the predicted branch, where a rollback resumes
    always_ff @(posedge clk) begin
        if (enable_i && bp_i.take) begin
            rollback_addr_q <= iaddr_advance;
        end
    end

    assign iaddr_o = {iaddr_q, {`FETCH_WORD_LSB{1'b0}}};

endmodule

`default_nettype wire

// File: verilog/fetch_data_hold.sv
/*
 * Keeps the memory word across a stall and forwards either the live
 * memory word or the held one to the issue stage.
 */

`default_nettype none

`include "fetch_macros.svh"

module fetch_data_hold (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   enable_i,

    input  wire logic [`FETCH_XLEN-1:0] idata_i,
    output logic [`FETCH_XLEN-1:0]      idata_o
);

    // High when memory saw a new address last cycle
    logic                   enable_q;
    logic [`FETCH_XLEN-1:0] idata_held_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_q <= 1'b0;
        end
        else begin
            enable_q <= enable_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stall capture
    //////////////////////////////////////////////////////////////////////

    // First stalled edge after an enabled cycle grabs the word in flight
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idata_held_q <= `FETCH_NOP;
        end
        else if (!enable_i && enable_q) begin
            idata_held_q <= idata_i;
        end
    end

    // Memory output is stale once a stall has passed an edge
    assign idata_o = enable_q ? idata_i : idata_held_q;

endmodule

`default_nettype wire

// File: verilog/fetch_issue.sv
/*
 * Issue side of the fetch stage. Tracks the redirect shadow and the
 * rollback flag, follows the PC of the arriving word and registers the
 * instruction and PC pair for decode.
 */

`default_nettype none

`include "fetch_macros.svh"

module fetch_issue (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     sys_reset_i,
    input  wire logic                     enable_i,

    input  wire fetch_pkg::fetch_reason_e reason_i,
    input  wire logic [`FETCH_XLEN-1:0]   iaddr_i,
    input  wire logic [`FETCH_XLEN-1:0]   idata_i,

    output logic [`FETCH_XLEN-1:0]        instruction_o,
    output logic [`FETCH_XLEN-1:0]        pc_o,
    output logic                          jumping_o,
    output logic                          bp_rollback_o
);

    logic                   jumped;
    logic                   rollback;
    logic                   jumped_q;
    logic                   rollback_q;
    logic [`FETCH_XLEN-1:0] iaddr_q;

    assign jumped = (reason_i == fetch_pkg::REASON_CTX)  ||
                    (reason_i == fetch_pkg::REASON_JUMP) ||
                    (reason_i == fetch_pkg::REASON_BP);

    assign rollback = (reason_i == fetch_pkg::REASON_ROLLBACK);

    //////////////////////////////////////////////////////////////////////
    // Redirect shadow
    //////////////////////////////////////////////////////////////////////

    // First stage of the shadow, the word in memory is squashed
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_q <= 1'b1;
        end
        else if (sys_reset_i) begin
            jumped_q <= 1'b1;
        end
        else if (jumped) begin
            jumped_q <= 1'b1;
        end
        else if (enable_i || rollback) begin
            jumped_q <= 1'b0;
        end
    end

    // Second stage; a rollback cuts the pending shadow short
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end
        else if (sys_reset_i) begin
            jumping_o <= 1'b1;
        end
        else if (jumped || (jumped_q && !rollback)) begin
            jumping_o <= 1'b1;
        end
        else if (enable_i || rollback) begin
            jumping_o <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Rollback flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_q <= 1'b0;
        end
        else if (sys_reset_i) begin
            rollback_q <= 1'b0;
        end
        else if (rollback) begin
            rollback_q <= 1'b1;
        end
        else if (enable_i) begin
            rollback_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bp_rollback_o <= 1'b0;
        end
        else if (sys_reset_i) begin
            bp_rollback_o <= 1'b0;
        end
        else if (enable_i) begin
            bp_rollback_o <= rollback_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // PC and instruction
    //////////////////////////////////////////////////////////////////////

    // Address that memory is answering this cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iaddr_q <= '0;
        end
        else if (jumped_q || enable_i) begin
            iaddr_q <= iaddr_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= '0;
        end
        else if (enable_i) begin
            pc_o <= iaddr_q;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= `FETCH_NOP;
        end
        else if (sys_reset_i) begin
            instruction_o <= `FETCH_NOP;
        end
        else if (enable_i) begin
            instruction_o <= idata_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
/*
 * Fetch stage top level. Joins the address path, the stall capture and
 * the issue registers between the core and the instruction memory.
 */

`default_nettype none

`include "fetch_macros.svh"

module fetch_top (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       sys_reset_i,
    input  wire logic                       enable_i,

    input  wire fetch_pkg::fetch_redirect_t redirect_i,
    input  wire fetch_pkg::fetch_bp_t       bp_i,

    // Instruction memory, data returns one cycle after the address
    output logic [`FETCH_XLEN-1:0]          instruction_address_o,
    input  wire logic [`FETCH_XLEN-1:0]     instruction_data_i,

    // Decode side
    output logic [`FETCH_XLEN-1:0]          instruction_o,
    output logic [`FETCH_XLEN-1:0]          pc_o,
    output logic                            jumping_o,
    output logic                            bp_rollback_o
);

    fetch_pkg::fetch_reason_e reason;
    logic [`FETCH_XLEN-1:0]   idata_sel;

    //////////////////////////////////////////////////////////////////////
    // Address path
    //////////////////////////////////////////////////////////////////////

    fetch_addr_gen u_fetch_addr_gen (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset_i),
        .enable_i    (enable_i),
        .redirect_i  (redirect_i),
        .bp_i        (bp_i),
        .reason_o    (reason),
        .iaddr_o     (instruction_address_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Data capture
    //////////////////////////////////////////////////////////////////////

    fetch_data_hold u_fetch_data_hold (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .idata_i  (instruction_data_i),
        .idata_o  (idata_sel)
    );

    //////////////////////////////////////////////////////////////////////
    // Issue
    //////////////////////////////////////////////////////////////////////

    fetch_issue u_fetch_issue (
        .clk           (clk),
        .reset_n       (reset_n),
        .sys_reset_i   (sys_reset_i),
        .enable_i      (enable_i),
        .reason_i      (reason),
        .iaddr_i       (instruction_address_o),
        .idata_i       (idata_sel),
        .instruction_o (instruction_o),
        .pc_o          (pc_o),
        .jumping_o     (jumping_o),
        .bp_rollback_o (bp_rollback_o)
    );

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
/*
 * Table-driven testbench for the fetch stage. A memory model answers each
 * address with a word derived from it, and a reference model tracks the
 * expected address, flags and instruction and PC pair row by row.
 */

`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS  = 35;
    localparam int NUM_TESTS = 6;

    typedef struct packed {
        logic [2:0]                 test_id;
        logic                       enable;
        logic                       sys_reset;
        fetch_pkg::fetch_redirect_t redirect;
        fetch_pkg::fetch_bp_t       bp;
        logic [`FETCH_XLEN-1:0]     exp_addr;
    } stim_row_t;

    logic                       clk;
    logic                       reset_n;
    logic                       sys_reset;
    logic                       enable;
    fetch_pkg::fetch_redirect_t redirect;
    fetch_pkg::fetch_bp_t       bp;
    logic [`FETCH_XLEN-1:0]     instr_addr;
    logic [`FETCH_XLEN-1:0]     instr_data = '0;
    logic [`FETCH_XLEN-1:0]     instruction;
    logic [`FETCH_XLEN-1:0]     pc;
    logic                       jumping;
    logic                       bp_rollback;

    // Reference model state
    logic [`FETCH_XLEN-1:0] model_addr;
    logic [`FETCH_XLEN-1:0] model_rb_addr;
    logic [`FETCH_XLEN-1:0] model_pc;
    logic [`FETCH_XLEN-1:0] model_prev_addr;
    int                     model_shadow;
    logic                   model_pend;
    logic                   model_flag;
    logic [`FETCH_XLEN-1:0] prev_pc;
    logic [`FETCH_XLEN-1:0] prev_instr;

    stim_row_t rows [NUM_ROWS];
    string     test_names [1:NUM_TESTS];
    int        test_errors [1:NUM_TESTS];
    int        current_test;
    int        error_count;
    int        check_count;
    int        tests_passed;

    fetch_top u_fetch_top (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset),
        .enable_i              (enable),
        .redirect_i            (redirect),
        .bp_i                  (bp),
        .instruction_address_o (instr_addr),
        .instruction_data_i    (instr_data),
        .instruction_o         (instruction),
        .pc_o                  (pc),
        .jumping_o             (jumping),
        .bp_rollback_o         (bp_rollback)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory word is the address with its upper half inverted
    function automatic logic [`FETCH_XLEN-1:0] mem_word(input logic [`FETCH_XLEN-1:0] addr);
        return {~addr[31:16], addr[15:0]};
    endfunction

    // Synchronous memory with one cycle of read latency
    always @(posedge clk) begin
        instr_data <= mem_word(instr_addr);
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////

    function automatic stim_row_t make_row(
        input int                     id,
        input logic                   en,
        input logic                   srst,
        input logic                   ctx,
        input logic [`FETCH_XLEN-1:0] ctx_target,
        input logic                   jmp,
        input logic [`FETCH_XLEN-1:0] jmp_target,
        input logic                   take,
        input logic                   rollback,
        input logic [`FETCH_XLEN-1:0] bp_target,
        input logic [`FETCH_XLEN-1:0] exp_addr
    );
        stim_row_t row;
        row.test_id              = id[2:0];
        row.enable               = en;
        row.sys_reset            = srst;
        row.redirect.ctx_switch  = ctx;
        row.redirect.ctx_target  = ctx_target;
        row.redirect.jump        = jmp;
        row.redirect.jump_target = jmp_target;
        row.bp.take              = take;
        row.bp.rollback          = rollback;
        row.bp.target            = bp_target;
        row.exp_addr             = exp_addr;
        return row;
    endfunction

    task automatic load_table();
        test_names[1] = "reset and soft reset";
        test_names[2] = "sequential fetch";
        test_names[3] = "redirect priority";
        test_names[4] = "stall";
        test_names[5] = "take while stalled";
        test_names[6] = "prediction and rollback";
        // id en srst ctx ctx_target jmp jmp_target take rb bp_target exp_addr
        rows[0]  = make_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0104);
        rows[1]  = make_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0108);
        rows[2]  = make_row(1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 32'h0100);
        rows[3]  = make_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0104);
        rows[4]  = make_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0108);
        rows[5]  = make_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h010c);
        rows[6]  = make_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0110);
        rows[7]  = make_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0114);
        rows[8]  = make_row(2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0118);
        rows[9]  = make_row(3, 1, 0, 1, 32'h2000, 1, 32'h3000, 0, 0, 0, 32'h2000);
        rows[10] = make_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h2004);
        rows[11] = make_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h2008);
        rows[12] = make_row(3, 1, 0, 0, 0, 1, 32'h3000, 0, 0, 0, 32'h3000);
        rows[13] = make_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h3004);
        rows[14] = make_row(3, 1, 0, 0, 0, 1, 32'h4000, 1, 0, 32'h5000, 32'h4000);
        rows[15] = make_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4004);
        rows[16] = make_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4008);
        rows[17] = make_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h400c);
        rows[18] = make_row(4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h400c);
        rows[19] = make_row(4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h400c);
        rows[20] = make_row(4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h400c);
        rows[21] = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4010);
        rows[22] = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4014);
        rows[23] = make_row(4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4014);
        rows[24] = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4018);
        rows[25] = make_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h401c);
        rows[26] = make_row(5, 0, 0, 0, 0, 0, 0, 1, 0, 32'h6000, 32'h401c);
        rows[27] = make_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4020);
        rows[28] = make_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4024);
        rows[29] = make_row(6, 1, 0, 0, 0, 0, 0, 1, 0, 32'h6000, 32'h6000);
        rows[30] = make_row(6, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h6004);
        rows[31] = make_row(6, 1, 0, 0, 0, 0, 0, 0, 1, 0, 32'h4028);
        rows[32] = make_row(6, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h402c);
        rows[33] = make_row(6, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4030);
        rows[34] = make_row(6, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4034);
    endtask

    task automatic drive_row(input stim_row_t row);
        enable    <= row.enable;
        sys_reset <= row.sys_reset;
        redirect  <= row.redirect;
        bp        <= row.bp;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        model_addr      = `FETCH_START_ADDR;
        model_rb_addr   = '0;
        model_pc        = '0;
        model_prev_addr = '0;
        model_shadow    = 2;
        model_pend      = 1'b0;
        model_flag      = 1'b0;
    endtask

    // Context switch, then jump, then an enabled take, then rollback
    function automatic logic [`FETCH_XLEN-1:0] next_address(
        input stim_row_t              row,
        input logic [`FETCH_XLEN-1:0] cur
    );
        if (row.sys_reset) begin
            return `FETCH_START_ADDR;
        end
        if (row.redirect.ctx_switch) begin
            return row.redirect.ctx_target;
        end
        if (row.redirect.jump) begin
            return row.redirect.jump_target;
        end
        if (row.enable && row.bp.take) begin
            return row.bp.target;
        end
        if (row.bp.rollback) begin
            return model_rb_addr;
        end
        if (row.enable) begin
            return cur + 32'd4;
        end
        return cur;
    endfunction

    task automatic step_model(input stim_row_t row);
        logic                   redirect_hit;
        logic                   rollback_hit;
        logic [`FETCH_XLEN-1:0] next;
        redirect_hit = row.redirect.ctx_switch || row.redirect.jump ||
                       (row.enable && row.bp.take);
        rollback_hit = !redirect_hit && row.bp.rollback;
        next = next_address(row, model_addr);
        if (row.enable && row.bp.take) begin
            model_rb_addr = model_addr + 32'd4;
        end
        // Issued PC is the address of the previous enabled cycle
        if (row.enable) begin
            model_pc        = model_prev_addr;
            model_prev_addr = model_addr;
        end
        model_addr = next;
        if (row.sys_reset) begin
            model_shadow = 2;
            model_pend   = 1'b0;
            model_flag   = 1'b0;
        end
        else begin
            // Two enabled edges of shadow after a redirect
            if (redirect_hit) begin
                model_shadow = 2;
            end
            else if (rollback_hit) begin
                model_shadow = 0;
            end
            else if (row.enable && model_shadow > 0) begin
                model_shadow = model_shadow - 1;
            end
            if (row.enable) begin
                model_flag = model_pend;
            end
            if (rollback_hit) begin
                model_pend = 1'b1;
            end
            else if (row.enable) begin
                model_pend = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Checks and reporting
    ////////////////////////////////////////////////////////////////////////

    task automatic note_error();
        error_count++;
        test_errors[current_test]++;
    endtask

    task automatic check_value(
        input string                  name,
        input logic [`FETCH_XLEN-1:0] got,
        input logic [`FETCH_XLEN-1:0] exp
    );
        check_count++;
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_reset_state();
        check_value("instruction_address_o", instr_addr, `FETCH_START_ADDR);
        check_value("instruction_o", instruction, `FETCH_NOP);
        check_value("pc_o", pc, '0);
        check_value("jumping_o", jumping, 1'b1);
        check_value("bp_rollback_o", bp_rollback, 1'b0);
        prev_pc    = pc;
        prev_instr = instruction;
    endtask

    task automatic check_row(input int idx);
        stim_row_t row;
        row = rows[idx];
        assert (row.exp_addr == model_addr) else begin
            $display("Table row %0d expects address %h but the reference model gives %h",
                     idx, row.exp_addr, model_addr);
            note_error();
        end
        check_value("instruction_address_o", instr_addr, model_addr);
        check_value("jumping_o", jumping, model_shadow != 0);
        check_value("bp_rollback_o", bp_rollback, model_flag);
        if (row.sys_reset) begin
            check_value("instruction_o", instruction, `FETCH_NOP);
        end
        else if (!row.enable) begin
            check_value("pc_o", pc, prev_pc);
            check_value("instruction_o", instruction, prev_instr);
        end
        // Outside the shadow the PC follows the model and the word matches it
        if (model_shadow == 0) begin
            check_value("pc_o", pc, model_pc);
            check_value("instruction_o", instruction, mem_word(model_pc));
        end
        prev_pc    = pc;
        prev_instr = instruction;
    endtask

    task automatic report_test(input int id);
        if (test_errors[id] == 0) begin
            tests_passed++;
            $display("test %0d, %s: passed", id, test_names[id]);
        end
        else begin
            $display("test %0d, %s: failed with %0d errors", id, test_names[id], test_errors[id]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        reset_n      = 1'b0;
        sys_reset    = 1'b0;
        enable       = 1'b0;
        redirect     = '0;
        bp           = '0;
        error_count  = 0;
        check_count  = 0;
        tests_passed = 0;
        current_test = 1;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            test_errors[t] = 0;
        end
        load_table();
        reset_model();

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        drive_row(rows[0]);
        @(negedge clk);
        check_reset_state();

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            current_test = rows[i].test_id;
            step_model(rows[i]);
            if (i + 1 < NUM_ROWS) begin
                drive_row(rows[i + 1]);
            end
            else begin
                drive_row('0);
            end
            @(negedge clk);
            check_row(i);
            if (i == NUM_ROWS - 1) begin
                report_test(rows[i].test_id);
            end
            else if (rows[i + 1].test_id != rows[i].test_id) begin
                report_test(rows[i].test_id);
            end
        end

        $display("%0d of %0d tests passed, %0d checks, %0d errors",
                 tests_passed, NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end
        else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Row count in clock periods plus twenty cycles of margin
    initial begin
        #((NUM_ROWS + 20) * 100);
        $display("Watchdog expired before the stimulus table was finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_addr_gen.sv
verilog/fetch_data_hold.sv
verilog/fetch_issue.sv
verilog/fetch_top.sv
dv/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_addr_gen.sv
      - verilog/fetch_data_hold.sv
      - verilog/fetch_issue.sv
      - verilog/fetch_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/fetch_tb.sv
